//--- bench/rv_core_properties.sv
//------------------------------
// pipeline control checks, bound into retire
// strobe shape, redirect pulse width and x0 writes
//------------------------------
`timescale 1ns/10ps
`default_nettype none

module rv_core_properties import rv_pkg::*; (
    input logic       clk,
    input logic       i_rst_n,
    input logic [3:0] i_write,     // store strobes of retire
    input logic       i_jump,      // redirect pulse
    input logic       i_reg_we,
    input reg_addr_t  i_reg_waddr
);

    // full-word stores only
    a_strobes_all_or_none: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_write == 4'b0000 || i_write == 4'b1111)
        else $error("partial store strobes 0x%h", i_write);

    // the slot behind a redirect carries a stale tag
    a_jump_single_cycle: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_jump |=> !i_jump)
        else $error("jump pulse held for two cycles");

    a_no_write_to_x0: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_reg_we |-> i_reg_waddr != 5'd0)
        else $error("register write aimed at x0");

endmodule

bind retire rv_core_properties props0 (
    .clk(clk), .i_rst_n(i_rst_n), .i_write(o_write), .i_jump(o_jump),
    .i_reg_we(o_reg_we), .i_reg_waddr(o_reg_waddr)
);

`default_nettype wire

//--- bench/tb_rv_core.sv
//------------------------------
// directed testbench of the rv32i core
// each test assembles a program, runs it to a store at 0xffc
// and compares the logged stores with reference values
//------------------------------
`timescale 1ns/10ps
`default_nettype none

module tb_rv_core;
    localparam logic [6:0] OPC_LUI    = 7'b0110111; // own copies of the opcodes
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;

    logic        clk, rst_n;
    logic [31:0] i_address, instruction, data_in, data_out, data_address;
    logic        enable;
    logic [3:0]  write;
    logic [31:0] imem [0:255];   // program, 1 KB
    logic [31:0] dmem [0:1023];  // data, 4 KB
    logic [31:0] st_addr[$], st_data[$], exp_addr[$], exp_data[$];
    logic [31:0] seed, store_addr;
    logic        done_seen;
    int          wp, errors, tests, failed_tests;

    rv_core #(.RESET_ADDR(32'h0)) dut0 (
        .clk(clk), .i_rst_n(rst_n), .o_i_address(i_address), .i_instruction(instruction),
        .i_data_in(data_in), .o_data_out(data_out), .o_data_address(data_address),
        .o_enable(enable), .o_write(write)
    );

    assign instruction = imem[i_address[9:2]];    // both memories answer at once
    assign data_in     = enable ? dmem[data_address[11:2]] : 32'h0; // only when selected

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // mid-cycle sampling of the store port
    always @(negedge clk) begin
        if (rst_n && enable && write == 4'b1111) begin
            if (data_address == 32'hFFC) begin
                done_seen = 1'b1;
            end else begin
                st_addr.push_back(data_address);
                st_data.push_back(data_out);
                dmem[data_address[11:2]] = data_out;
            end
        end
    end

    function automatic logic [31:0] lcg_next();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return {~addr[15:0], addr[15:0]}; // unique per byte address
    endfunction

    function automatic logic [31:0] sext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE}; // sw
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
    endfunction

    function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, OPC_LUI};
    endfunction

    function automatic logic [2:0] funct3_of(input int op);
        case (op)
            0, 1:    return 3'b000; // add, sub
            2:       return 3'b111;
            3:       return 3'b110;
            4:       return 3'b100;
            default: return 3'b010; // slt
        endcase
    endfunction

    // rv32i result of add, sub, and, or, xor, slt
    function automatic logic [31:0] alu_ref(input int op, input logic [31:0] a,
                                            input logic [31:0] b);
        case (op)
            0:       return a + b;
            1:       return a - b;
            2:       return a & b;
            3:       return a | b;
            4:       return a ^ b;
            default: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        endcase
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAILED %s got 0x%08h expected 0x%08h", name, got, exp);
            errors++;
        end
    endtask

    task automatic fill_memories();
        for (int i = 0; i < 256; i++) begin
            imem[i] = enc_i(i[11:0], 5'd0, 3'b000, 5'd0, OPC_OPIMM); // addi x0, x0, index
        end
        for (int i = 0; i < 1024; i++) begin
            dmem[i] = fill_word(i * 4);
        end
    endtask

    task automatic emit(input logic [31:0] word);
        imem[wp] = word;
        wp++;
    endtask

    task automatic load_const(input logic [4:0] rd, input logic [31:0] val);
        logic [31:0] hi;
        hi = val + 32'h800; // undo the sign of the low part
        emit(enc_u(hi[31:12], rd));
        emit(enc_i(val[11:0], rd, 3'b000, rd, OPC_OPIMM));
    endtask

    // sw rs, next slot; the value is expected in the log only when listed
    task automatic store_at(input logic [4:0] rs, input logic [31:0] val, input logic listed);
        emit(enc_s(store_addr[11:0], rs, 5'd0));
        if (listed) begin
            exp_addr.push_back(store_addr);
            exp_data.push_back(val);
        end
        store_addr = store_addr + 32'd4;
    endtask

    task automatic start_program();
        @(posedge clk);
        #5 rst_n = 1'b0;
        fill_memories();
        exp_addr.delete();
        exp_data.delete();
        wp = 0;
        store_addr = 32'h100;
        emit(enc_u(20'h00001, 5'd31)); // x31 = 0x1000, base of the done store
    endtask

    task automatic compare_log(input string name);
        check({name, " store count"}, st_addr.size(), exp_addr.size());
        for (int i = 0; i < exp_addr.size() && i < st_addr.size(); i++) begin
            check($sformatf("%s o_data_address[%0d]", name, i), st_addr[i], exp_addr[i]);
            check($sformatf("%s o_data_out[%0d]", name, i), st_data[i], exp_data[i]);
        end
    endtask

    task automatic finish_program(input string name);
        int cycles;
        int errs_before;
        errs_before = errors;
        emit(enc_s(12'hFFC, 5'd0, 5'd31)); // done store at 0x1000 - 4
        emit(enc_j(21'd0, 5'd0));          // park on itself
        st_addr.delete();
        st_data.delete();
        done_seen = 1'b0;
        repeat (3) @(posedge clk);
        #5 rst_n = 1'b1;
        cycles = 0;
        while (!done_seen && cycles < 500) begin
            @(posedge clk);
            cycles++;
        end
        if (!done_seen) begin
            $display("%s: program never reached done store", name);
            errors++;
        end else begin
            compare_log(name);
        end
        tests++;
        if (errors == errs_before) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errors - errs_before);
            failed_tests++;
        end
    endtask

    task automatic arith_test();
        logic [31:0] a, b, imm;
        start_program();
        for (int k = 0; k < 3; k++) begin
            a = lcg_next();
            b = lcg_next();
            imm = lcg_next();
            imm = sext12(imm[11:0]);
            load_const(5'd1, a);
            load_const(5'd2, b);
            for (int op = 0; op < 6; op++) begin
                emit(enc_r(op == 1 ? 7'h20 : 7'h00, 5'd2, 5'd1, funct3_of(op), 5'd3));
                store_at(5'd3, alu_ref(op, a, b), 1'b1);
                if (op != 1) begin // sub has no immediate form
                    emit(enc_i(imm[11:0], 5'd1, funct3_of(op), 5'd3, OPC_OPIMM));
                    store_at(5'd3, alu_ref(op, a, imm), 1'b1);
                end
            end
        end
        finish_program("arith");
    endtask

    task automatic chain_test();
        logic [31:0] c, i1, i2, v5, v6, v7, v8, v9;
        start_program();
        c = lcg_next();
        i1 = lcg_next();
        i2 = lcg_next();
        load_const(5'd5, c);
        emit(enc_i(i1[11:0], 5'd5, 3'b000, 5'd5, OPC_OPIMM));  // addi x5, x5
        emit(enc_r(7'h00, 5'd5, 5'd5, 3'b000, 5'd6));           // add x6, x5, x5
        emit(enc_r(7'h20, 5'd5, 5'd6, 3'b000, 5'd7));           // sub x7, x6, x5
        emit(enc_i(i2[11:0], 5'd7, 3'b100, 5'd7, OPC_OPIMM));  // xori x7, x7
        emit(enc_r(7'h00, 5'd6, 5'd7, 3'b110, 5'd8));           // or x8, x7, x6
        emit(enc_r(7'h00, 5'd5, 5'd8, 3'b111, 5'd9));           // and x9, x8, x5
        emit(enc_r(7'h00, 5'd7, 5'd9, 3'b000, 5'd9));           // add x9, x9, x7
        v5 = c + sext12(i1[11:0]);
        v6 = v5 + v5;
        v7 = (v6 - v5) ^ sext12(i2[11:0]);
        v8 = v7 | v6;
        v9 = (v8 & v5) + v7;
        store_at(5'd9, v9, 1'b1);
        finish_program("chain");
    endtask

    task automatic load_test();
        logic [31:0] p, q;
        start_program();
        p = lcg_next();
        q = lcg_next();
        dmem[10'h080] = p; // 0x200
        dmem[10'h081] = q; // 0x204
        emit(enc_i(12'h200, 5'd0, 3'b010, 5'd10, OPC_LOAD));
        emit(enc_i(12'h204, 5'd0, 3'b010, 5'd11, OPC_LOAD));
        emit(enc_r(7'h00, 5'd11, 5'd10, 3'b000, 5'd12));  // load-use on x11
        store_at(5'd12, p + q, 1'b1);                      // lands at 0x100
        load_const(5'd13, 32'h300);
        emit(enc_i(12'h008, 5'd13, 3'b010, 5'd14, OPC_LOAD)); // untouched word at 0x308
        store_at(5'd14, fill_word(32'h308), 1'b1);
        emit(enc_i(12'h100, 5'd0, 3'b010, 5'd15, OPC_LOAD));  // reads back the first store
        store_at(5'd15, p + q, 1'b1);
        finish_program("load");
    endtask

    task automatic branch_case(input logic [2:0] f3, input logic [4:0] rs2,
                               input logic taken, input logic [31:0] a);
        emit(enc_b(13'd12, rs2, 5'd1, f3)); // skips two words when taken
        store_at(5'd1, a, !taken);
        store_at(5'd1, a, !taken);
        store_at(5'd1, a, 1'b1);            // join point
    endtask

    task automatic branch_test();
        logic [31:0] a;
        start_program();
        a = lcg_next();
        load_const(5'd1, a);
        load_const(5'd2, a);
        load_const(5'd3, a ^ 32'h1);
        branch_case(3'b000, 5'd2, 1'b1, a); // beq, equal
        branch_case(3'b000, 5'd3, 1'b0, a);
        branch_case(3'b001, 5'd3, 1'b1, a); // bne, differ
        branch_case(3'b001, 5'd2, 1'b0, a);
        finish_program("branch");
    endtask

    task automatic jal_test();
        logic [31:0] link;
        start_program();
        load_const(5'd1, 32'h0BAD_0BAD);
        link = wp * 4 + 4; // pc of the jal plus 4
        emit(enc_j(21'd16, 5'd20));
        store_at(5'd1, 32'h0, 1'b0); // three skipped words
        store_at(5'd1, 32'h0, 1'b0);
        store_at(5'd1, 32'h0, 1'b0);
        store_at(5'd20, link, 1'b1);
        finish_program("jal");
    endtask

    task automatic zero_reg_test();
        start_program();
        emit(enc_i(12'h123, 5'd0, 3'b000, 5'd0, OPC_OPIMM)); // addi x0, x0, 0x123
        store_at(5'd0, 32'h0, 1'b1);
        emit(enc_u(20'hABCDE, 5'd0));                         // lui x0
        emit(enc_i(12'h005, 5'd0, 3'b000, 5'd21, OPC_OPIMM)); // x21 = x0 + 5
        store_at(5'd21, 32'd5, 1'b1);
        finish_program("x0");
    endtask

    initial begin
        rst_n = 1'b0;
        seed = 32'd30371;
        errors = 0;
        tests = 0;
        failed_tests = 0;
        wp = 0;
        done_seen = 1'b0;
        store_addr = 32'h100;
        fill_memories();
        arith_test();
        chain_test();
        load_test();
        branch_test();
        jal_test();
        zero_reg_test();
        $display("%0d tests, %0d failed, %0d check errors", tests, failed_tests, errors);
        if (errors == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- list.f
verilog/rv_pkg.sv
verilog/pipe_if.sv
verilog/fetch.sv
verilog/regbank.sv
verilog/decoder.sv
verilog/execute.sv
verilog/retire.sv
verilog/rv_core.sv
bench/rv_core_properties.sv
bench/tb_rv_core.sv

//--- run.sh
#!/usr/bin/env bash
# build the rv_core testbench with verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_rv_core \
    -f list.f -o sim_tb_rv_core \
  && ./obj_dir/sim_tb_rv_core | tee /dev/stderr | grep -qx "STATUS: PASS" \
  && { echo "simulation passed"; exit 0; } \
  || { echo "simulation failed"; exit 1; }

//--- verilog/decoder.sv
//------------------------------
// decode stage: class and alu op, immediates, operand select
// stalls on a register hazard and sends a bubble to execute meanwhile
//------------------------------
`timescale 1ns/10ps
`default_nettype none

module decoder import rv_pkg::*; (
    input  logic       clk,
    input  logic       i_rst_n,
    input  word_t      i_instruction,
    input  word_t      i_pc,
    input  word_t      i_npc,
    input  tag_t       i_tag,
    input  logic       i_valid,
    input  word_t      i_rdata_a,
    input  word_t      i_rdata_b,
    input  reg_addr_t  i_ret_wr_addr, // destination of the instruction in retire
    input  logic       i_ret_we,      // already qualified by its valid
    output reg_addr_t  o_raddr_a,
    output reg_addr_t  o_raddr_b,
    output logic       o_stall,
    exec_bus_if.master o_ex_bus
);
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    reg_addr_t  rd;
    word_t      imm_i, imm_s, imm_b, imm_j, imm_u;
    op_class_e  op_class;
    alu_op_e    alu_op;
    word_t      opa, opb, opc;
    logic       writes;
    logic       hazard_a, hazard_b;

    assign opcode    = i_instruction[6:0];
    assign rd        = i_instruction[11:7];
    assign funct3    = i_instruction[14:12];
    assign funct7    = i_instruction[31:25];
    assign o_raddr_a = i_instruction[19:15];
    assign o_raddr_b = i_instruction[24:20];

    // sign extended immediates of each format
    assign imm_i = {{20{i_instruction[31]}}, i_instruction[31:20]};
    assign imm_s = {{20{i_instruction[31]}}, i_instruction[31:25], i_instruction[11:7]};
    assign imm_b = {{19{i_instruction[31]}}, i_instruction[31], i_instruction[7],
                    i_instruction[30:25], i_instruction[11:8], 1'b0};
    assign imm_j = {{11{i_instruction[31]}}, i_instruction[31], i_instruction[19:12],
                    i_instruction[20], i_instruction[30:21], 1'b0};
    assign imm_u = {i_instruction[31:12], 12'b0};

    always_comb begin
        op_class = OP_NOP; // unknown encodings fall through as nop
        alu_op   = ALU_ADD;
        case (opcode)
            OPC_LUI:   op_class = OP_LUI;
            OPC_JAL:   op_class = OP_JAL;
            OPC_LOAD:  if (funct3 == 3'b010) op_class = OP_LOAD;  // lw only
            OPC_STORE: if (funct3 == 3'b010) op_class = OP_STORE; // sw only
            OPC_BRANCH: begin
                if (funct3 == 3'b000 || funct3 == 3'b001) begin
                    op_class = OP_BRANCH;
                    alu_op   = funct3[0] ? ALU_NE : ALU_EQ;
                end
            end
            OPC_OPIMM, OPC_OP: begin
                op_class = OP_ALU;
                case (funct3)
                    3'b000:  alu_op = (opcode == OPC_OP && funct7[5]) ? ALU_SUB : ALU_ADD;
                    3'b010:  alu_op = ALU_SLT;
                    3'b100:  alu_op = ALU_XOR;
                    3'b110:  alu_op = ALU_OR;
                    3'b111:  alu_op = ALU_AND;
                    default: op_class = OP_NOP; // shifts, sltu
                endcase
                if (opcode == OPC_OP && funct7 != 7'b0 &&
                    !(funct7 == 7'b0100000 && funct3 == 3'b000))
                    op_class = OP_NOP;
            end
            default: ;
        endcase
    end

    always_comb begin
        opa = i_rdata_a;
        opb = i_rdata_b;
        opc = i_rdata_b; // store data by default
        case (op_class)
            OP_LUI: begin
                opa = '0;
                opb = imm_u;
            end
            OP_JAL: begin
                opa = i_pc; // target = pc + offset in execute
                opb = imm_j;
            end
            OP_BRANCH: opc = imm_b; // rs1 vs rs2 compared on opa/opb
            OP_LOAD:   opb = imm_i;
            OP_STORE:  opb = imm_s;
            OP_ALU:    if (opcode == OPC_OPIMM) opb = imm_i;
            default: ;
        endcase
    end

    assign writes = (op_class == OP_ALU || op_class == OP_LOAD ||
                     op_class == OP_JAL || op_class == OP_LUI) && rd != '0;

    // no forwarding, wait until the producer has left retire
    assign hazard_a = o_raddr_a != '0 &&
                      ((o_ex_bus.valid && o_ex_bus.we && o_ex_bus.wr_addr == o_raddr_a) ||
                       (i_ret_we && i_ret_wr_addr == o_raddr_a));
    assign hazard_b = o_raddr_b != '0 &&
                      ((o_ex_bus.valid && o_ex_bus.we && o_ex_bus.wr_addr == o_raddr_b) ||
                       (i_ret_we && i_ret_wr_addr == o_raddr_b));
    assign o_stall  = i_valid & (hazard_a | hazard_b);

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n)
            o_ex_bus.valid <= 1'b0;
        else
            o_ex_bus.valid <= i_valid & ~o_stall; // bubble while stalled
    end

    always_ff @(posedge clk) begin
        o_ex_bus.op_class <= op_class;
        o_ex_bus.alu_op   <= alu_op;
        o_ex_bus.opa      <= opa;
        o_ex_bus.opb      <= opb;
        o_ex_bus.opc      <= opc;
        o_ex_bus.npc      <= i_npc;
        o_ex_bus.wr_addr  <= rd;
        o_ex_bus.we       <= writes;
        o_ex_bus.tag      <= i_tag;
    end

endmodule

`default_nettype wire

//--- verilog/execute.sv
//------------------------------
// execute stage: alu, branch and jal resolution, memory address
// one adder serves add, load/store address and jal target
//------------------------------
`timescale 1ns/10ps
`default_nettype none

module execute import rv_pkg::*; (
    input  logic      clk,
    input  logic      i_rst_n,
    exec_bus_if.slave i_ex_bus,
    ret_bus_if.master o_ret_bus
);
    word_t sum;
    word_t alu_out;
    word_t result;
    word_t target;
    logic  taken;

    assign sum = i_ex_bus.opa + i_ex_bus.opb;

    always_comb begin
        case (i_ex_bus.alu_op)
            ALU_ADD: alu_out = sum;
            ALU_SUB: alu_out = i_ex_bus.opa - i_ex_bus.opb;
            ALU_AND: alu_out = i_ex_bus.opa & i_ex_bus.opb;
            ALU_OR:  alu_out = i_ex_bus.opa | i_ex_bus.opb;
            ALU_XOR: alu_out = i_ex_bus.opa ^ i_ex_bus.opb;
            ALU_SLT: alu_out = {31'b0, $signed(i_ex_bus.opa) < $signed(i_ex_bus.opb)};
            ALU_EQ:  alu_out = {31'b0, i_ex_bus.opa == i_ex_bus.opb};
            ALU_NE:  alu_out = {31'b0, i_ex_bus.opa != i_ex_bus.opb};
            default: alu_out = '0;
        endcase
    end

    always_comb begin
        result = alu_out; // alu and lui
        taken  = 1'b0;
        target = sum;     // jal: pc + imm
        case (i_ex_bus.op_class)
            OP_JAL: begin
                result = i_ex_bus.npc; // link address
                taken  = 1'b1;
            end
            OP_BRANCH: begin
                taken  = alu_out[0];
                target = i_ex_bus.npc - 32'd4 + i_ex_bus.opc; // pc + offset
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n)
            o_ret_bus.valid <= 1'b0;
        else
            o_ret_bus.valid <= i_ex_bus.valid;
    end

    always_ff @(posedge clk) begin
        o_ret_bus.op_class   <= i_ex_bus.op_class;
        o_ret_bus.result     <= result;
        o_ret_bus.mem_addr   <= sum;           // rs1 + imm
        o_ret_bus.store_data <= i_ex_bus.opc;  // rs2 for stores
        o_ret_bus.jump       <= taken;
        o_ret_bus.target     <= target;
        o_ret_bus.wr_addr    <= i_ex_bus.wr_addr;
        o_ret_bus.we         <= i_ex_bus.we;
        o_ret_bus.tag        <= i_ex_bus.tag;
    end

endmodule

`default_nettype wire

//--- verilog/fetch.sv
//------------------------------
// fetch stage: pc register and path tag
// pc goes straight to the instruction memory, the word returns same cycle
//------------------------------
`timescale 1ns/10ps
`default_nettype none

module fetch import rv_pkg::*; #(
    parameter word_t RESET_ADDR = '0
) (
    input  logic  clk,
    input  logic  i_rst_n,
    input  logic  i_stall,  // decoder holds the current instruction
    input  logic  i_jump,   // redirect pulse from retire
    input  word_t i_target,
    output word_t o_pc,
    output word_t o_npc,
    output tag_t  o_tag,
    output logic  o_valid
);
    word_t pc;
    tag_t  tag;
    logic  run;  // low for the first cycle out of reset

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            pc  <= RESET_ADDR;
            tag <= '0;
            run <= 1'b0;
        end else begin
            run <= 1'b1;
            if (i_jump) begin
                pc  <= i_target;   // redirect wins over a stall
                tag <= tag + 1'b1; // new path, older work gets killed
            end else if (run && !i_stall) begin
                pc <= pc + 32'd4;
            end
        end
    end

    assign o_pc    = pc;
    assign o_npc   = pc + 32'd4;
    assign o_tag   = tag;
    assign o_valid = run & ~i_jump; // word at the old pc is dropped on redirect

endmodule

`default_nettype wire

//--- verilog/pipe_if.sv
//------------------------------
// stage-to-stage buses of the pipeline
// exec_bus_if: decoder to execute, ret_bus_if: execute to retire
//------------------------------
`timescale 1ns/10ps
`default_nettype none

interface exec_bus_if import rv_pkg::*; ();
    logic      valid;    // stage register holds a live instruction
    op_class_e op_class;
    alu_op_e   alu_op;
    word_t     opa;      // rs1, pc or zero
    word_t     opb;      // rs2 or immediate
    word_t     opc;      // store data or branch offset
    word_t     npc;      // pc + 4, link value
    reg_addr_t wr_addr;
    logic      we;       // writes a register other than x0
    tag_t      tag;

    modport master (output valid, op_class, alu_op, opa, opb, opc, npc, wr_addr, we, tag);
    modport slave  (input  valid, op_class, alu_op, opa, opb, opc, npc, wr_addr, we, tag);
endinterface

interface ret_bus_if import rv_pkg::*; ();
    logic      valid;
    op_class_e op_class;
    word_t     result;     // alu result or link address
    word_t     mem_addr;   // rs1 + offset for loads and stores
    word_t     store_data;
    logic      jump;       // taken branch or jal
    word_t     target;
    reg_addr_t wr_addr;
    logic      we;
    tag_t      tag;

    modport master (output valid, op_class, result, mem_addr, store_data, jump, target,
                    wr_addr, we, tag);
    modport slave  (input  valid, op_class, result, mem_addr, store_data, jump, target,
                    wr_addr, we, tag);
endinterface

`default_nettype wire

//--- verilog/regbank.sv
//------------------------------
// register file, 31 writable entries
// two combinational reads with write bypass, x0 is hardwired zero
//------------------------------
`timescale 1ns/10ps
`default_nettype none

module regbank import rv_pkg::*; (
    input  logic      clk,
    input  logic      i_rst_n,
    input  reg_addr_t i_raddr_a,
    input  reg_addr_t i_raddr_b,
    input  logic      i_we,
    input  reg_addr_t i_waddr,
    input  word_t     i_wdata,
    output word_t     o_rdata_a,
    output word_t     o_rdata_b
);
    word_t regs [1:31]; // no storage for x0

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we && i_waddr != '0) begin
            regs[i_waddr] <= i_wdata; // writes to x0 fall away
        end
    end

    function automatic word_t read_port(input reg_addr_t addr);
        if (addr == '0)
            return '0;
        if (i_we && addr == i_waddr)
            return i_wdata; // value being written this cycle
        return regs[addr];
    endfunction

    always_comb begin
        o_rdata_a = read_port(i_raddr_a);
        o_rdata_b = read_port(i_raddr_b);
    end

endmodule

`default_nettype wire

//--- verilog/retire.sv
//------------------------------
// retire stage: memory access, write-back, redirect
// only instructions tagged with the current path commit
//------------------------------
`timescale 1ns/10ps
`default_nettype none

module retire import rv_pkg::*; (
    input  logic       clk,
    input  logic       i_rst_n,
    ret_bus_if.slave   i_ret_bus,
    input  word_t      i_data_in,      // load data, returned in the same cycle
    output logic       o_reg_we,
    output reg_addr_t  o_reg_waddr,
    output word_t      o_reg_wdata,
    output logic       o_jump,
    output word_t      o_target,
    output logic [3:0] o_write,        // byte strobes, all or none
    output word_t      o_data_address,
    output word_t      o_data_out,
    output logic       o_read
);
    tag_t cur_tag;
    logic commit;
    logic is_load;

    assign commit  = i_ret_bus.valid && i_ret_bus.tag == cur_tag; // stale path is killed
    assign is_load = i_ret_bus.op_class == OP_LOAD;

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n)
            cur_tag <= '0;
        else if (o_jump)
            cur_tag <= cur_tag + 1'b1; // follows the fetch tag
    end

    assign o_write        = (commit && i_ret_bus.op_class == OP_STORE) ? 4'b1111 : 4'b0000;
    assign o_read         = commit & is_load;
    assign o_data_address = i_ret_bus.mem_addr;
    assign o_data_out     = i_ret_bus.store_data;

    assign o_reg_we    = commit & i_ret_bus.we;
    assign o_reg_waddr = i_ret_bus.wr_addr;
    assign o_reg_wdata = is_load ? i_data_in : i_ret_bus.result;

    assign o_jump   = commit & i_ret_bus.jump; // one-cycle pulse
    assign o_target = i_ret_bus.target;

endmodule

`default_nettype wire

//--- verilog/rv_core.sv
//------------------------------
// top of the four-stage rv32i core
// instruction and data memories sit outside and answer combinationally
//------------------------------
`timescale 1ns/10ps
`default_nettype none

module rv_core import rv_pkg::*; #(
    parameter word_t RESET_ADDR = '0
) (
    input  logic       clk,
    input  logic       i_rst_n,
    output word_t      o_i_address,    // pc to instruction memory
    input  word_t      i_instruction,
    input  word_t      i_data_in,
    output word_t      o_data_out,
    output word_t      o_data_address, // word aligned
    output logic       o_enable,       // data memory select
    output logic [3:0] o_write
);
    word_t     npc, retire_target, retire_addr;
    tag_t      fetch_tag;
    logic      fetch_valid, stall, retire_jump, retire_read;
    reg_addr_t raddr_a, raddr_b, reg_waddr;
    word_t     rdata_a, rdata_b, reg_wdata;
    logic      reg_we;
    logic      ret_we;

    exec_bus_if ex_bus ();
    ret_bus_if  ret_bus ();

    assign ret_we = ret_bus.valid & ret_bus.we; // hazard snoop on retire

    fetch #(.RESET_ADDR(RESET_ADDR)) fetch0 (
        .clk(clk), .i_rst_n(i_rst_n), .i_stall(stall), .i_jump(retire_jump),
        .i_target(retire_target), .o_pc(o_i_address), .o_npc(npc),
        .o_tag(fetch_tag), .o_valid(fetch_valid)
    );

    regbank regbank0 (
        .clk(clk), .i_rst_n(i_rst_n), .i_raddr_a(raddr_a), .i_raddr_b(raddr_b),
        .i_we(reg_we), .i_waddr(reg_waddr), .i_wdata(reg_wdata),
        .o_rdata_a(rdata_a), .o_rdata_b(rdata_b)
    );

    decoder decoder0 (
        .clk(clk), .i_rst_n(i_rst_n), .i_instruction(i_instruction), .i_pc(o_i_address),
        .i_npc(npc), .i_tag(fetch_tag), .i_valid(fetch_valid), .i_rdata_a(rdata_a),
        .i_rdata_b(rdata_b), .i_ret_wr_addr(ret_bus.wr_addr), .i_ret_we(ret_we),
        .o_raddr_a(raddr_a), .o_raddr_b(raddr_b), .o_stall(stall), .o_ex_bus(ex_bus)
    );

    execute execute0 (
        .clk(clk), .i_rst_n(i_rst_n), .i_ex_bus(ex_bus), .o_ret_bus(ret_bus)
    );

    retire retire0 (
        .clk(clk), .i_rst_n(i_rst_n), .i_ret_bus(ret_bus), .i_data_in(i_data_in),
        .o_reg_we(reg_we), .o_reg_waddr(reg_waddr), .o_reg_wdata(reg_wdata),
        .o_jump(retire_jump), .o_target(retire_target), .o_write(o_write),
        .o_data_address(retire_addr), .o_data_out(o_data_out), .o_read(retire_read)
    );

    assign o_data_address = {retire_addr[31:2], 2'b00};
    assign o_enable       = (|o_write) | retire_read;

endmodule

`default_nettype wire

//--- verilog/rv_pkg.sv
//------------------------------
// shared types and constants of the rv32i core
// modules take them with import rv_pkg::* in their header
//------------------------------
`default_nettype none

package rv_pkg;

    typedef logic [31:0] word_t;     // data word, instruction or address
    typedef logic [4:0]  reg_addr_t; // register index x0..x31
    typedef logic [3:0]  tag_t;      // path tag, bumped on every taken jump

    // instruction class, decided in decode
    typedef enum logic [2:0] {
        OP_NOP,
        OP_ALU,
        OP_LOAD,
        OP_STORE,
        OP_BRANCH,
        OP_JAL,
        OP_LUI
    } op_class_e;

    // alu operation, EQ and NE only serve branches
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_EQ,
        ALU_NE
    } alu_op_e;

    // major opcodes of the supported subset
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;

endpackage

`default_nettype wire
